// ==== build.f ====
+incdir+src
src/bilinear_pkg.sv
src/line_buffer.sv
src/coord_driver.sv
src/reverse_mapper.sv
src/bilinear_interp.sv
src/bilinear_xform.sv
tests/tb_bilinear_xform.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the bilinear warp testbench, verdict comes from the log
LOG=sim.log
rm -f "$LOG"
verilator --binary --timing -Wno-fatal -f build.f --top-module tb_bilinear_xform \
    --Mdir obj_dir -o sim_bilinear > "$LOG" 2>&1 \
    && ./obj_dir/sim_bilinear >> "$LOG" 2>&1 \
    || echo "CHECKS FAILED (build or simulation returned an error)" >> "$LOG"
cat "$LOG"
if grep -q "CHECKS FAILED" "$LOG"; then
    echo "simulation failed"
    exit 1
fi
echo "simulation passed"

// ==== src/bilinear_consts.svh ====
// Bilinear warp constants
`ifndef BILINEAR_CONSTS_SVH
`define BILINEAR_CONSTS_SVH

//////////////////////////////
// frame geometry
//////////////////////////////

// frame width in pixels, kept even so both column banks match
`define BX_WIDTH 16
// frame height in lines
`define BX_HEIGHT 8

// buffered lines as a power of two (2 -> four lines)
`define BX_LINES_POW2 2

// first input row/col at which the output raster may start
`define BX_PIPE_ROW 2
`define BX_PIPE_COL 0

//////////////////////////////
// number formats
//////////////////////////////

// fraction bits of mapped coordinates and blend weights
`define BX_PRECISION 8
// unsigned pixel width
`define BX_PIXEL_BITS 8
// signed row/col width
`define BX_COORD_BITS 16
// integer bits of a matrix coefficient, sign included
`define BX_COEF_INT_BITS 11

`endif

// ==== src/bilinear_interp.sv ====
// Bilinear interpolation pipeline
`timescale 1ns/1ns
`include "bilinear_consts.svh"

module bilinear_interp (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  bilinear_pkg::coord_t  row_i,
    input  bilinear_pkg::coord_t  col_i,
    input  bilinear_pkg::coord_t  row_int_i,
    input  bilinear_pkg::coord_t  col_int_i,
    input  bilinear_pkg::frac_t   row_frac_i,
    input  bilinear_pkg::frac_t   col_frac_i,
    input  logic                  valid_i,
    input  bilinear_pkg::pixel_t  q11_i,
    input  bilinear_pkg::pixel_t  q21_i,
    input  bilinear_pkg::pixel_t  q12_i,
    input  bilinear_pkg::pixel_t  q22_i,
    output bilinear_pkg::coord_t  req_row_o,
    output bilinear_pkg::coord_t  req_col_o,
    output bilinear_pkg::pixel_t  pixel_o,
    output bilinear_pkg::coord_t  row_o,
    output bilinear_pkg::coord_t  col_o,
    output logic                  valid_o
);
    // room for pixel << precision plus a signed weighted difference
    localparam int ACC_BITS = `BX_PIXEL_BITS + `BX_PRECISION + 4;

    // stage 0 request, stage 1 buffer data, stage 2 top/bot
    bilinear_pkg::coord_t row_pipe [3];
    bilinear_pkg::coord_t col_pipe [3];
    logic                 valid_pipe [3];
    // column weight needed at stage 1, row weight at stage 2
    bilinear_pkg::frac_t  xf_pipe [2];
    bilinear_pkg::frac_t  yf_pipe [3];

    bilinear_pkg::pixel_t top_d;
    bilinear_pkg::pixel_t bot_d;
    bilinear_pkg::pixel_t top_q;
    bilinear_pkg::pixel_t bot_q;

    // a + floor(w * (b - a) / 2^precision), stays within [a, b]
    function automatic bilinear_pkg::pixel_t lerp(input bilinear_pkg::pixel_t a,
                                                  input bilinear_pkg::pixel_t b,
                                                  input bilinear_pkg::frac_t  w);
        logic signed [ACC_BITS-1:0] a_x;
        logic signed [ACC_BITS-1:0] b_x;
        logic signed [ACC_BITS-1:0] w_x;
        logic signed [ACC_BITS-1:0] acc;
        a_x = ACC_BITS'(a);
        b_x = ACC_BITS'(b);
        w_x = ACC_BITS'(w);
        acc = (a_x <<< `BX_PRECISION) + w_x * (b_x - a_x);
        return acc[`BX_PRECISION +: `BX_PIXEL_BITS];
    endfunction

    //////////////////////////////
    // horizontal blends
    //////////////////////////////
    assign top_d = lerp(q11_i, q21_i, xf_pipe[1]);
    assign bot_d = lerp(q12_i, q22_i, xf_pipe[1]);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_pipe[0] <= 1'b0;
            valid_pipe[1] <= 1'b0;
            valid_pipe[2] <= 1'b0;
        end else begin
            valid_pipe[0] <= valid_i;
            valid_pipe[1] <= valid_pipe[0];
            valid_pipe[2] <= valid_pipe[1];
        end
        // stage 0, integer parts become the buffer request
        req_row_o   <= row_int_i;
        req_col_o   <= col_int_i;
        row_pipe[0] <= row_i;
        col_pipe[0] <= col_i;
        xf_pipe[0]  <= col_frac_i;
        yf_pipe[0]  <= row_frac_i;
        // stage 1, buffer read in flight
        row_pipe[1] <= row_pipe[0];
        col_pipe[1] <= col_pipe[0];
        xf_pipe[1]  <= xf_pipe[0];
        yf_pipe[1]  <= yf_pipe[0];
        // stage 2, neighbours arrived and top/bot captured
        row_pipe[2] <= row_pipe[1];
        col_pipe[2] <= col_pipe[1];
        yf_pipe[2]  <= yf_pipe[1];
        top_q       <= top_d;
        bot_q       <= bot_d;
    end

    // vertical blend straight to the output
    assign pixel_o = lerp(top_q, bot_q, yf_pipe[2]);
    assign row_o   = row_pipe[2];
    assign col_o   = col_pipe[2];
    assign valid_o = valid_pipe[2];

endmodule

// ==== src/bilinear_pkg.sv ====
// Bilinear warp types
`include "bilinear_consts.svh"

package bilinear_pkg;

    //////////////////////////////
    // data types
    //////////////////////////////

    // unsigned pixel sample
    typedef logic [`BX_PIXEL_BITS-1:0] pixel_t;

    // signed row or column, negative values come out of the mapper
    typedef logic signed [`BX_COORD_BITS-1:0] coord_t;

    // fraction part of a mapped coordinate, also the blend weight
    typedef logic [`BX_PRECISION-1:0] frac_t;

    // matrix coefficient, signed fixed point with PRECISION fraction bits
    typedef logic signed [`BX_COEF_INT_BITS+`BX_PRECISION-1:0] coef_t;

    //////////////////////////////
    // coordinate driver FSM
    //////////////////////////////

    // fill   waiting for enough lines in the buffer
    // run    one output coordinate per valid input
    // flush  input frame done, one output coordinate per cycle
    typedef enum logic [1:0] {
        DRV_FILL  = 2'd0,
        DRV_RUN   = 2'd1,
        DRV_FLUSH = 2'd2
    } drv_state_e;

endpackage

// ==== src/bilinear_xform.sv ====
// Bilinear warp engine top
`timescale 1ns/1ns

module bilinear_xform (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  bilinear_pkg::pixel_t  in_pixel_i,
    input  bilinear_pkg::coord_t  in_row_i,
    input  bilinear_pkg::coord_t  in_col_i,
    input  logic                  in_valid_i,
    input  bilinear_pkg::coef_t   matrix_i [6],
    output bilinear_pkg::pixel_t  out_pixel_o,
    output bilinear_pkg::coord_t  out_row_o,
    output bilinear_pkg::coord_t  out_col_o,
    output logic                  out_valid_o
);
    // driver to mapper
    bilinear_pkg::coord_t drv_row;
    bilinear_pkg::coord_t drv_col;
    logic                 drv_valid;

    // mapper to interpolator
    bilinear_pkg::coord_t map_row;
    bilinear_pkg::coord_t map_col;
    bilinear_pkg::coord_t map_row_int;
    bilinear_pkg::coord_t map_col_int;
    bilinear_pkg::frac_t  map_row_frac;
    bilinear_pkg::frac_t  map_col_frac;
    logic                 map_valid;

    // interpolator to and from the buffer
    bilinear_pkg::coord_t req_row;
    bilinear_pkg::coord_t req_col;
    bilinear_pkg::pixel_t q11;
    bilinear_pkg::pixel_t q21;
    bilinear_pkg::pixel_t q12;
    bilinear_pkg::pixel_t q22;

    coord_driver u_driver (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .in_row_i   (in_row_i),
        .in_col_i   (in_col_i),
        .in_valid_i (in_valid_i),
        .row_o      (drv_row),
        .col_o      (drv_col),
        .valid_o    (drv_valid)
    );

    reverse_mapper u_mapper (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .row_i      (drv_row),
        .col_i      (drv_col),
        .valid_i    (drv_valid),
        .matrix_i   (matrix_i),
        .row_o      (map_row),
        .col_o      (map_col),
        .row_int_o  (map_row_int),
        .col_int_o  (map_col_int),
        .row_frac_o (map_row_frac),
        .col_frac_o (map_col_frac),
        .valid_o    (map_valid)
    );

    // three cycles, request, buffer read, top/bot
    bilinear_interp u_interp (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .row_i      (map_row),
        .col_i      (map_col),
        .row_int_i  (map_row_int),
        .col_int_i  (map_col_int),
        .row_frac_i (map_row_frac),
        .col_frac_i (map_col_frac),
        .valid_i    (map_valid),
        .q11_i      (q11),
        .q21_i      (q21),
        .q12_i      (q12),
        .q22_i      (q22),
        .req_row_o  (req_row),
        .req_col_o  (req_col),
        .pixel_o    (out_pixel_o),
        .row_o      (out_row_o),
        .col_o      (out_col_o),
        .valid_o    (out_valid_o)
    );

    line_buffer u_buffer (
        .clk        (clk),
        .wr_pixel_i (in_pixel_i),
        .wr_row_i   (in_row_i),
        .wr_col_i   (in_col_i),
        .wr_valid_i (in_valid_i),
        .req_row_i  (req_row),
        .req_col_i  (req_col),
        .q11_o      (q11),
        .q21_o      (q21),
        .q12_o      (q12),
        .q22_o      (q22)
    );

endmodule

// ==== src/coord_driver.sv ====
// Output raster coordinate driver
`timescale 1ns/1ns
`include "bilinear_consts.svh"

module coord_driver (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  bilinear_pkg::coord_t  in_row_i,
    input  bilinear_pkg::coord_t  in_col_i,
    input  logic                  in_valid_i,
    output bilinear_pkg::coord_t  row_o,
    output bilinear_pkg::coord_t  col_o,
    output logic                  valid_o
);
    bilinear_pkg::drv_state_e state_q;
    bilinear_pkg::drv_state_e state_d;
    bilinear_pkg::coord_t     row_q;
    bilinear_pkg::coord_t     row_d;
    bilinear_pkg::coord_t     col_q;
    bilinear_pkg::coord_t     col_d;

    logic issue;
    logic pipe_full;
    logic last_in;
    logic last_out;

    // enough lines stored once input reaches the start point
    assign pipe_full = in_valid_i && (in_row_i >= `BX_PIPE_ROW) && (in_col_i >= `BX_PIPE_COL);
    // final pixel of the input frame
    assign last_in = in_valid_i && (in_row_i == `BX_HEIGHT - 1) && (in_col_i == `BX_WIDTH - 1);
    // final coordinate of the output raster
    assign last_out = (row_q == `BX_HEIGHT - 1) && (col_q == `BX_WIDTH - 1);

    always_comb begin
        state_d = state_q;
        row_d   = row_q;
        col_d   = col_q;
        issue   = 1'b0;
        case (state_q)
            bilinear_pkg::DRV_FILL: begin
                if (pipe_full) begin
                    state_d = bilinear_pkg::DRV_RUN;
                end
            end
            bilinear_pkg::DRV_RUN: begin
                // locked to the input pixel rate
                issue = in_valid_i;
                if (last_in) begin
                    state_d = bilinear_pkg::DRV_FLUSH;
                end
            end
            bilinear_pkg::DRV_FLUSH: begin
                issue = 1'b1;
            end
            default: begin
                state_d = bilinear_pkg::DRV_FILL;
            end
        endcase
        // raster advance on each issued coordinate
        if (issue) begin
            if (col_q == `BX_WIDTH - 1) begin
                col_d = '0;
                row_d = row_q + bilinear_pkg::coord_t'(1);
            end else begin
                col_d = col_q + bilinear_pkg::coord_t'(1);
            end
            // raster complete, wrap and wait for the next frame
            if (last_out) begin
                row_d   = '0;
                col_d   = '0;
                state_d = bilinear_pkg::DRV_FILL;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= bilinear_pkg::DRV_FILL;
            row_q   <= '0;
            col_q   <= '0;
        end else begin
            state_q <= state_d;
            row_q   <= row_d;
            col_q   <= col_d;
        end
    end

    assign row_o   = row_q;
    assign col_o   = col_q;
    assign valid_o = issue;

endmodule

// ==== src/line_buffer.sv ====
// Four-bank line buffer
`timescale 1ns/1ns
`include "bilinear_consts.svh"

module line_buffer (
    input  logic                  clk,
    input  bilinear_pkg::pixel_t  wr_pixel_i,
    input  bilinear_pkg::coord_t  wr_row_i,
    input  bilinear_pkg::coord_t  wr_col_i,
    input  logic                  wr_valid_i,
    input  bilinear_pkg::coord_t  req_row_i,
    input  bilinear_pkg::coord_t  req_col_i,
    output bilinear_pkg::pixel_t  q11_o,
    output bilinear_pkg::pixel_t  q21_o,
    output bilinear_pkg::pixel_t  q12_o,
    output bilinear_pkg::pixel_t  q22_o
);
    // banks indexed {row[0], col[0]}: 0 even/even, 1 even/odd, 2 odd/even, 3 odd/odd
    localparam int BANK_COLS  = `BX_WIDTH / 2;
    localparam int LINE_PAIRS = (1 << `BX_LINES_POW2) / 2;
    localparam int DEPTH      = BANK_COLS * LINE_PAIRS;
    localparam int ADDR_BITS  = $clog2(DEPTH);

    bilinear_pkg::pixel_t mem [4][DEPTH];
    bilinear_pkg::pixel_t rd_data [4];
    logic [ADDR_BITS-1:0] rd_addr [4];

    // neighbour order 0 q11, 1 q21, 2 q12, 3 q22
    bilinear_pkg::coord_t nb_row [4];
    bilinear_pkg::coord_t nb_col [4];
    logic [1:0] sel_d [4];
    logic [1:0] sel_q [4];
    logic       inb_d [4];
    logic       inb_q [4];
    bilinear_pkg::pixel_t q [4];

    logic [1:0]           wr_bank;
    logic [ADDR_BITS-1:0] wr_addr;

    // bank of a coordinate from row/col parity
    function automatic logic [1:0] bank_sel(input bilinear_pkg::coord_t row,
                                            input bilinear_pkg::coord_t col);
        return {row[0], col[0]};
    endfunction

    // line pair within the ring times bank row length, plus column halved
    function automatic logic [ADDR_BITS-1:0] bank_addr(input bilinear_pkg::coord_t row,
                                                       input bilinear_pkg::coord_t col);
        int pair;
        int half;
        pair = int'(row[`BX_LINES_POW2-1:1]);
        half = int'(col[`BX_COORD_BITS-1:1]);
        return ADDR_BITS'(pair * BANK_COLS + half);
    endfunction

    function automatic logic in_frame(input bilinear_pkg::coord_t row,
                                      input bilinear_pkg::coord_t col);
        return (row >= 0) && (row < `BX_HEIGHT) && (col >= 0) && (col < `BX_WIDTH);
    endfunction

    //////////////////////////////
    // write side
    //////////////////////////////
    assign wr_bank = bank_sel(wr_row_i, wr_col_i);
    assign wr_addr = bank_addr(wr_row_i, wr_col_i);

    //////////////////////////////
    // read address steering
    //////////////////////////////
    always_comb begin
        nb_row[0] = req_row_i;
        nb_col[0] = req_col_i;
        nb_row[1] = req_row_i;
        nb_col[1] = req_col_i + bilinear_pkg::coord_t'(1);
        nb_row[2] = req_row_i + bilinear_pkg::coord_t'(1);
        nb_col[2] = req_col_i;
        nb_row[3] = nb_row[2];
        nb_col[3] = nb_col[1];
        for (int b = 0; b < 4; b++) begin
            rd_addr[b] = '0;
        end
        // the four neighbours always land in four different banks
        for (int n = 0; n < 4; n++) begin
            sel_d[n] = bank_sel(nb_row[n], nb_col[n]);
            rd_addr[sel_d[n]] = bank_addr(nb_row[n], nb_col[n]);
            // an out-of-frame anchor zeroes all four
            inb_d[n] = in_frame(nb_row[n], nb_col[n]) && in_frame(req_row_i, req_col_i);
        end
    end

    always_ff @(posedge clk) begin
        if (wr_valid_i) begin
            mem[wr_bank][wr_addr] <= wr_pixel_i;
        end
        for (int b = 0; b < 4; b++) begin
            rd_data[b] <= mem[b][rd_addr[b]];
            sel_q[b]   <= sel_d[b];
            inb_q[b]   <= inb_d[b];
        end
    end

    // back to neighbour order, masked by the registered bounds flags
    always_comb begin
        for (int n = 0; n < 4; n++) begin
            q[n] = inb_q[n] ? rd_data[sel_q[n]] : '0;
        end
    end

    assign q11_o = q[0];
    assign q21_o = q[1];
    assign q12_o = q[2];
    assign q22_o = q[3];

endmodule

// ==== src/reverse_mapper.sv ====
// Affine reverse mapper
`timescale 1ns/1ns
`include "bilinear_consts.svh"

module reverse_mapper (
    input  logic                  clk,
    input  logic                  rst_n_i,
    input  bilinear_pkg::coord_t  row_i,
    input  bilinear_pkg::coord_t  col_i,
    input  logic                  valid_i,
    input  bilinear_pkg::coef_t   matrix_i [6],
    output bilinear_pkg::coord_t  row_o,
    output bilinear_pkg::coord_t  col_o,
    output bilinear_pkg::coord_t  row_int_o,
    output bilinear_pkg::coord_t  col_int_o,
    output bilinear_pkg::frac_t   row_frac_o,
    output bilinear_pkg::frac_t   col_frac_o,
    output logic                  valid_o
);
    // coordinates enter the multipliers as 11-bit signed, range -1024..1023
    localparam int MAP_COORD_BITS = 11;
    localparam int COEF_BITS      = `BX_COEF_INT_BITS + `BX_PRECISION;
    // product plus headroom for the three-term sum
    localparam int SUM_BITS       = COEF_BITS + MAP_COORD_BITS + 2;

    logic signed [MAP_COORD_BITS-1:0] row_s;
    logic signed [MAP_COORD_BITS-1:0] col_s;
    logic signed [SUM_BITS-1:0]       row_x;
    logic signed [SUM_BITS-1:0]       col_x;
    logic signed [SUM_BITS-1:0]       m_x [6];
    logic signed [SUM_BITS-1:0]       row_sum;
    logic signed [SUM_BITS-1:0]       col_sum;

    assign row_s = row_i[MAP_COORD_BITS-1:0];
    assign col_s = col_i[MAP_COORD_BITS-1:0];

    //////////////////////////////
    // affine sums
    //////////////////////////////
    always_comb begin
        // sign extend everything to the sum width first
        row_x = SUM_BITS'(row_s);
        col_x = SUM_BITS'(col_s);
        for (int k = 0; k < 6; k++) begin
            m_x[k] = SUM_BITS'(matrix_i[k]);
        end
        // source col = m00*col + m01*row + m02
        col_sum = m_x[0] * col_x + m_x[1] * row_x + m_x[2];
        // source row = m10*col + m11*row + m12
        row_sum = m_x[3] * col_x + m_x[4] * row_x + m_x[5];
    end

    // two's complement split gives a floored integer part
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= valid_i;
        end
        row_o      <= row_i;
        col_o      <= col_i;
        row_int_o  <= row_sum[`BX_PRECISION +: `BX_COORD_BITS];
        col_int_o  <= col_sum[`BX_PRECISION +: `BX_COORD_BITS];
        row_frac_o <= row_sum[`BX_PRECISION-1:0];
        col_frac_o <= col_sum[`BX_PRECISION-1:0];
    end

endmodule

// ==== tests/tb_bilinear_xform.sv ====
// Bilinear warp testbench
`timescale 1ns/1ns
`include "bilinear_consts.svh"

module tb_bilinear_xform;

    localparam int NUM_CASES      = 4;
    localparam int FRAME_PIXELS   = `BX_WIDTH * `BX_HEIGHT;
    // worst case per frame is two idle cycles per pixel plus flush and drain
    localparam int TIMEOUT_CYCLES = NUM_CASES * (3 * FRAME_PIXELS + 64);
    localparam int ONE            = 1 << `BX_PRECISION;

    logic                 clk;
    logic                 rst_n_i;
    bilinear_pkg::pixel_t in_pixel_i;
    bilinear_pkg::coord_t in_row_i;
    bilinear_pkg::coord_t in_col_i;
    logic                 in_valid_i;
    bilinear_pkg::coef_t  matrix_i [6];
    bilinear_pkg::pixel_t out_pixel_o;
    bilinear_pkg::coord_t out_row_o;
    bilinear_pkg::coord_t out_col_o;
    logic                 out_valid_o;

    // case table with one row per frame
    string case_name   [NUM_CASES];
    int    case_coef   [NUM_CASES][6];
    int    probe_row   [NUM_CASES];
    int    probe_col   [NUM_CASES];
    int    probe_pixel [NUM_CASES];
    int    loaded_cases;

    int cur_case;
    int out_count;
    int cycle_count;
    int fail_count;

    bilinear_xform uut (
        .clk         (clk),
        .rst_n_i     (rst_n_i),
        .in_pixel_i  (in_pixel_i),
        .in_row_i    (in_row_i),
        .in_col_i    (in_col_i),
        .in_valid_i  (in_valid_i),
        .matrix_i    (matrix_i),
        .out_pixel_o (out_pixel_o),
        .out_row_o   (out_row_o),
        .out_col_o   (out_col_o),
        .out_valid_o (out_valid_o)
    );

    always #50 clk = ~clk;

    //////////////////////////////
    // table and reference model
    //////////////////////////////

    // coefficients in m00 m01 m02 m10 m11 m12 order with 8 fraction bits
    task automatic add_case(input string name, input int m00, input int m01, input int m02,
                            input int m10, input int m11, input int m12,
                            input int pr, input int pc, input int pp);
        case_name[loaded_cases]   = name;
        case_coef[loaded_cases]   = '{m00, m01, m02, m10, m11, m12};
        probe_row[loaded_cases]   = pr;
        probe_col[loaded_cases]   = pc;
        probe_pixel[loaded_cases] = pp;
        loaded_cases++;
    endtask

    // input frame content and zero outside the frame
    function automatic int frame_pixel(input int r, input int c);
        if (r < 0 || r >= `BX_HEIGHT || c < 0 || c >= `BX_WIDTH) begin
            return 0;
        end
        return (r * `BX_WIDTH + c) & 8'hff;
    endfunction

    // weighted sum of two samples whose weights add up to one
    function automatic int blend(input int a, input int b, input int w);
        return ((ONE - w) * a + w * b) / ONE;
    endfunction

    function automatic bilinear_pkg::pixel_t model_pixel(input int idx, input int r,
                                                         input int c);
        int sx;
        int sy;
        int xi;
        int yi;
        int top;
        int bot;
        sx = case_coef[idx][0] * c + case_coef[idx][1] * r + case_coef[idx][2];
        sy = case_coef[idx][3] * c + case_coef[idx][4] * r + case_coef[idx][5];
        // arithmetic shift floors negative source coordinates
        xi = sx >>> `BX_PRECISION;
        yi = sy >>> `BX_PRECISION;
        // anchor outside the frame zeroes all four neighbours
        if (yi < 0 || yi >= `BX_HEIGHT || xi < 0 || xi >= `BX_WIDTH) begin
            return '0;
        end
        top = blend(frame_pixel(yi, xi), frame_pixel(yi, xi + 1), sx & (ONE - 1));
        bot = blend(frame_pixel(yi + 1, xi), frame_pixel(yi + 1, xi + 1), sx & (ONE - 1));
        return bilinear_pkg::pixel_t'(blend(top, bot, sy & (ONE - 1)));
    endfunction

    //////////////////////////////
    // compare tasks
    //////////////////////////////

    task automatic check_pixel(input string name, input bilinear_pkg::pixel_t exp_val,
                               input bilinear_pkg::pixel_t act_val);
        if (exp_val !== act_val) begin
            $display("[FAIL] %s expected %0d actual %0d", name, exp_val, act_val);
            fail_count++;
            $display("CHECKS FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic check_coord(input string name, input bilinear_pkg::coord_t exp_val,
                               input bilinear_pkg::coord_t act_val);
        if (exp_val !== act_val) begin
            $display("[FAIL] %s expected %0d actual %0d", name, exp_val, act_val);
            fail_count++;
            $display("CHECKS FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic check_count(input string name, input int exp_val, input int act_val);
        if (exp_val != act_val) begin
            $display("[FAIL] %s expected %0d actual %0d", name, exp_val, act_val);
            fail_count++;
            $display("CHECKS FAILED");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    //////////////////////////////
    // stimulus
    //////////////////////////////

    // one raster frame with 0..2 idle cycles before each pixel
    task automatic drive_frame();
        int gap;
        for (int r = 0; r < `BX_HEIGHT; r++) begin
            for (int c = 0; c < `BX_WIDTH; c++) begin
                gap = $urandom_range(2, 0);
                repeat (gap) begin
                    @(negedge clk);
                    in_valid_i = 1'b0;
                end
                @(negedge clk);
                in_pixel_i = bilinear_pkg::pixel_t'(frame_pixel(r, c));
                in_row_i   = bilinear_pkg::coord_t'(r);
                in_col_i   = bilinear_pkg::coord_t'(c);
                in_valid_i = 1'b1;
            end
        end
        @(negedge clk);
        in_valid_i = 1'b0;
    endtask

    // each valid output against its raster position and the model
    always @(negedge clk) begin : collect_outputs
        int exp_row;
        int exp_col;
        if (rst_n_i && out_valid_o) begin
            exp_row = out_count / `BX_WIDTH;
            exp_col = out_count % `BX_WIDTH;
            check_coord($sformatf("%s row of output %0d", case_name[cur_case], out_count),
                        bilinear_pkg::coord_t'(exp_row), out_row_o);
            check_coord($sformatf("%s col of output %0d", case_name[cur_case], out_count),
                        bilinear_pkg::coord_t'(exp_col), out_col_o);
            check_pixel($sformatf("%s pixel at (%0d,%0d)", case_name[cur_case], exp_row,
                        exp_col), model_pixel(cur_case, exp_row, exp_col), out_pixel_o);
            if (exp_row == probe_row[cur_case] && exp_col == probe_col[cur_case]) begin
                check_pixel($sformatf("%s probe", case_name[cur_case]),
                            bilinear_pkg::pixel_t'(probe_pixel[cur_case]), out_pixel_o);
            end
            out_count++;
        end
    end

    // run limit counted from the end of reset
    always @(posedge clk) begin
        if (rst_n_i) begin
            cycle_count++;
            if (cycle_count >= TIMEOUT_CYCLES) begin
                $display("simulation timed out after %0d cycles", cycle_count);
                $display("CHECKS FAILED");
                $fatal(1, "timeout");
            end
        end
    end

    initial begin
        clk          = 1'b0;
        rst_n_i      = 1'b0;
        in_pixel_i   = '0;
        in_row_i     = '0;
        in_col_i     = '0;
        in_valid_i   = 1'b0;
        for (int k = 0; k < 6; k++) begin
            matrix_i[k] = '0;
        end
        loaded_cases = 0;
        cur_case     = 0;
        out_count    = 0;
        cycle_count  = 0;
        fail_count   = 0;
        void'($urandom(42));

        //          name           m00 m01  m02  m10 m11 m12  row col pixel
        add_case("identity",      256, 0,    0,  0, 256,  0,  3,  5, 53);
        // right neighbour of column 15 is outside the frame
        add_case("col_half",      256, 0,  128,  0, 256,  0,  2, 15, 23);
        // bottom neighbour of row 7 is outside the frame
        add_case("row_quarter",   256, 0,    0,  0, 256, 64,  7,  4, 87);
        add_case("col_minus_two", 256, 0, -512,  0, 256,  0,  5,  1,  0);

        repeat (16) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;

        for (int i = 0; i < loaded_cases; i++) begin
            // matrix only changes while the pipeline is empty
            @(negedge clk);
            for (int k = 0; k < 6; k++) begin
                matrix_i[k] = bilinear_pkg::coef_t'(case_coef[i][k]);
            end
            cur_case  = i;
            out_count = 0;
            drive_frame();
            while (out_count < FRAME_PIXELS) begin
                @(posedge clk);
            end
            // a few idle cycles to catch any extra output
            repeat (8) @(posedge clk);
            check_count($sformatf("%s output count", case_name[i]), FRAME_PIXELS, out_count);
        end

        if (fail_count == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule
